//--- build.f
+incdir+design
design/rv_pkg.sv
design/rvAlu.sv
design/rvImmGen.sv
design/rvControl.sv
design/rvDatapath.sv
design/rvCore.sv
bench/rvCore_assertions.sv
bench/rvCore_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module rvCore_tb \
	-o rvCoreSim > build.log 2>&1 \
	&& ./obj_dir/rvCoreSim > sim.log 2>&1 \
	|| { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "^TESTS PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- bench/rvCore_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvCore_tb;

	localparam int resetCycles = 8;
	localparam int progLen = 25;
	localparam int traceLen = 13;
	localparam int memRows = 3;
	// executed path, ebreak included
	localparam int expectedRetired = 20;
	// up to 30 instructions at 5 cycles each, plus reset and some slack
	localparam int cycleLimit = 200;

	logic CLK;
	logic rstN;
	logic [`RV_AW-1:0] iMemAddr;
	logic [`RV_XLEN-1:0] iMemData;
	logic [`RV_AW-1:0] dMemAddr;
	logic [`RV_XLEN-1:0] dMemRdata;
	logic [`RV_XLEN-1:0] dMemWdata;
	logic dMemWe;
	logic rfWe;
	logic [4:0] rfRa1;
	logic [4:0] rfRa2;
	logic [4:0] rfWa;
	logic [`RV_XLEN-1:0] rfRd1;
	logic [`RV_XLEN-1:0] rfRd2;
	logic [`RV_XLEN-1:0] rfWd;
	logic halt;
	logic [`RV_XLEN-1:0] numInst;

	logic [`RV_XLEN-1:0] imem [0:1023];
	logic [`RV_XLEN-1:0] dmem [0:1023];
	logic [`RV_XLEN-1:0] regs [0:31];
	logic [`RV_XLEN-1:0] progTable [0:progLen-1];
	int traceIdx = 0;
	int cycles = 0;

	// register writes in order: {rd, value}
	logic [36:0] traceTable [0:traceLen-1] = '{
		{5'd1, 32'h0000_0006},
		{5'd2, 32'hFFFF_FFFD},
		{5'd3, 32'h0000_0003},
		{5'd4, 32'h0000_0009},
		{5'd5, 32'h0000_0004},
		{5'd6, 32'hFFFF_FFFF},
		{5'd7, 32'hFFFF_FFFB},
		{5'd8, 32'h0000_0001},
		{5'd9, 32'h0000_0000},
		{5'd10, 32'h0000_0009},
		{5'd12, 32'h0000_0002},
		{5'd14, 32'h0000_004C},
		{5'd16, 32'h0000_004B}
	};

	// data memory after the run: {byte address, word}
	logic [43:0] memTable [0:memRows-1] = '{
		{12'd16, 32'd9},
		{12'd20, 32'd76},
		{12'd24, 32'd0}
	};

	rvCore i_rvCore (
		.CLK(CLK), .rstN(rstN), .iMemAddr(iMemAddr), .iMemData(iMemData),
		.dMemAddr(dMemAddr), .dMemRdata(dMemRdata), .dMemWdata(dMemWdata),
		.dMemWe(dMemWe), .rfWe(rfWe), .rfRa1(rfRa1), .rfRa2(rfRa2),
		.rfWa(rfWa), .rfRd1(rfRd1), .rfRd2(rfRd2), .rfWd(rfWd),
		.halt(halt), .numInst(numInst)
	);

	function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_RTYPE};
	endfunction

	function automatic logic [31:0] immWord(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
	endfunction

	// offset bit 0 is implied
	function automatic logic [31:0] branchWord(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] jalWord(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			failRun($sformatf("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual));
	endtask

	// memories and register file, reads are combinational
	assign iMemData = imem[iMemAddr[`RV_AW-1:2]];
	assign dMemRdata = dmem[dMemAddr[`RV_AW-1:2]];
	assign rfRd1 = (rfRa1 == 5'd0) ? '0 : regs[rfRa1];
	assign rfRd2 = (rfRa2 == 5'd0) ? '0 : regs[rfRa2];

	always @(posedge CLK) begin
		if (dMemWe)
			dmem[dMemAddr[`RV_AW-1:2]] <= dMemWdata;
		if (rfWe && rfWa != 5'd0)
			regs[rfWa] <= rfWd;
	end

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
			failRun($sformatf("timeout: core did not halt within %0d cycles", cycleLimit));
	end

	// sampled mid-cycle where the strobe is settled
	always @(negedge CLK) begin
		if (rstN === 1'b1 && rfWe === 1'b1) begin
			if (traceIdx >= traceLen) begin
				failRun($sformatf("unexpected write to register x%0d after the trace ended",
					rfWa));
			end else begin
				checkValue("rfWa", {27'd0, traceTable[traceIdx][36:32]}, {27'd0, rfWa});
				checkValue("rfWd", traceTable[traceIdx][31:0], rfWd);
				traceIdx++;
			end
		end
	end

	initial begin
		rstN = 1'b0;
		progTable[0] = immWord(12'd6, 5'd0, `RV_F3_ADDSUB, 5'd1, `RV_OP_ITYPE);
		// -3
		progTable[1] = immWord(12'hFFD, 5'd0, `RV_F3_ADDSUB, 5'd2, `RV_OP_ITYPE);
		progTable[2] = rTypeWord(7'd0, 5'd2, 5'd1, `RV_F3_ADDSUB, 5'd3);
		progTable[3] = rTypeWord(`RV_F7_SUB, 5'd2, 5'd1, `RV_F3_ADDSUB, 5'd4);
		progTable[4] = rTypeWord(7'd0, 5'd2, 5'd1, `RV_F3_AND, 5'd5);
		progTable[5] = rTypeWord(7'd0, 5'd2, 5'd1, `RV_F3_OR, 5'd6);
		progTable[6] = rTypeWord(7'd0, 5'd2, 5'd1, `RV_F3_XOR, 5'd7);
		progTable[7] = rTypeWord(7'd0, 5'd1, 5'd2, `RV_F3_SLT, 5'd8);
		progTable[8] = rTypeWord(7'd0, 5'd2, 5'd1, `RV_F3_SLT, 5'd9);
		progTable[9] = storeWord(12'd16, 5'd4, 5'd0);
		progTable[10] = immWord(12'd16, 5'd0, 3'b010, 5'd10, `RV_OP_LOAD);
		// taken, skips x11
		progTable[11] = branchWord(13'd8, 5'd4, 5'd10, `RV_F3_BEQ);
		progTable[12] = immWord(12'd1, 5'd0, `RV_F3_ADDSUB, 5'd11, `RV_OP_ITYPE);
		progTable[13] = branchWord(13'd8, 5'd4, 5'd10, `RV_F3_BNE);
		progTable[14] = immWord(12'd2, 5'd0, `RV_F3_ADDSUB, 5'd12, `RV_OP_ITYPE);
		progTable[15] = branchWord(13'd8, 5'd2, 5'd1, `RV_F3_BNE);
		progTable[16] = immWord(12'd3, 5'd0, `RV_F3_ADDSUB, 5'd13, `RV_OP_ITYPE);
		progTable[17] = branchWord(13'd8, 5'd2, 5'd1, `RV_F3_BEQ);
		// jal at 72 lands on 84
		progTable[18] = jalWord(21'd12, 5'd14);
		progTable[19] = immWord(12'd4, 5'd0, `RV_F3_ADDSUB, 5'd15, `RV_OP_ITYPE);
		progTable[20] = immWord(12'd5, 5'd0, `RV_F3_ADDSUB, 5'd15, `RV_OP_ITYPE);
		progTable[21] = storeWord(12'd20, 5'd14, 5'd0);
		progTable[22] = immWord(12'hFFF, 5'd14, `RV_F3_ADDSUB, 5'd16, `RV_OP_ITYPE);
		progTable[23] = `RV_EBREAK;
		progTable[24] = immWord(12'd7, 5'd0, `RV_F3_ADDSUB, 5'd17, `RV_OP_ITYPE);
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
			dmem[i] = '0;
		end
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < progLen; i++)
			imem[i] = progTable[i];

		repeat (resetCycles - 1) @(posedge CLK);
		@(negedge CLK);
		checkValue("rfWe", 32'd0, {31'd0, rfWe});
		checkValue("dMemWe", 32'd0, {31'd0, dMemWe});
		checkValue("halt", 32'd0, {31'd0, halt});
		checkValue("numInst", 32'd0, numInst);
		@(posedge CLK);
		#1 rstN = 1'b1;
		// first fetch still in progress
		@(negedge CLK);
		checkValue("iMemAddr", 32'd0, {20'd0, iMemAddr});
		checkValue("rfWe", 32'd0, {31'd0, rfWe});

		while (halt !== 1'b1)
			@(negedge CLK);
		repeat (4) @(negedge CLK);
		checkValue("halt", 32'd1, {31'd0, halt});
		checkValue("numInst", expectedRetired, numInst);
		checkValue("traceIdx", traceLen, traceIdx);
		for (int i = 0; i < memRows; i++)
			checkValue($sformatf("dmem[%0d]", memTable[i][43:32]), memTable[i][31:0],
				dmem[memTable[i][43:34]]);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/rvCore_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvCore_assertions (
	input wire CLK,
	input wire rstN,
	input wire rfWe,
	input wire dMemWe,
	input wire halt,
	input wire [`RV_AW-1:0] iMemAddr
);

	// one write strobe per cycle at most
	strobesExclusive: assert property (@(posedge CLK) disable iff (!rstN)
		!(rfWe && dMemWe))
		else $error("rfWe and dMemWe high in the same cycle");

	quietAfterHalt: assert property (@(posedge CLK) disable iff (!rstN)
		halt |=> (halt && !rfWe && !dMemWe))
		else $error("halt dropped or a write strobe fired while halted");

	// pc only moves in words
	fetchAligned: assert property (@(posedge CLK) disable iff (!rstN)
		iMemAddr[1:0] == 2'b00)
		else $error("iMemAddr %h is not word aligned", iMemAddr);

endmodule

bind rvCore rvCore_assertions i_rvCoreAssertions (
	.CLK(CLK), .rstN(rstN), .rfWe(rfWe), .dMemWe(dMemWe),
	.halt(halt), .iMemAddr(iMemAddr)
);

`default_nettype wire

//--- design/rvCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvCore (
	input wire CLK,
	input wire rstN,
	output logic [`RV_AW-1:0] iMemAddr,
	input wire [`RV_XLEN-1:0] iMemData,
	output logic [`RV_AW-1:0] dMemAddr,
	input wire [`RV_XLEN-1:0] dMemRdata,
	output logic [`RV_XLEN-1:0] dMemWdata,
	output logic dMemWe,
	output logic rfWe,
	output logic [4:0] rfRa1,
	output logic [4:0] rfRa2,
	output logic [4:0] rfWa,
	input wire [`RV_XLEN-1:0] rfRd1,
	input wire [`RV_XLEN-1:0] rfRd2,
	output logic [`RV_XLEN-1:0] rfWd,
	output logic halt,
	output logic [`RV_XLEN-1:0] numInst
);

	rv_pkg::instrT ir;
	rv_pkg::aluSrcAT aluSrcA;
	rv_pkg::aluSrcBT aluSrcB;
	logic pcWrite;
	logic irWrite;
	logic wbFromMem;
	logic pcFromAluOut;
	logic zero;
	logic [2:0] aluOp;
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] aluA;
	logic [`RV_XLEN-1:0] aluB;
	logic [`RV_XLEN-1:0] aluResult;
	logic [`RV_XLEN-1:0] aluOut;

	// register addresses straight from the instruction register
	assign rfRa1 = ir.rType.rs1;
	assign rfRa2 = ir.rType.rs2;
	assign rfWa = ir.rType.rd;
	assign dMemAddr = aluOut[`RV_AW-1:0];

	rvControl i_rvControl (
		.CLK(CLK), .rstN(rstN), .ir(ir), .zero(zero),
		.pcWrite(pcWrite), .irWrite(irWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.wbFromMem(wbFromMem), .pcFromAluOut(pcFromAluOut),
		.rfWe(rfWe), .dMemWe(dMemWe), .halt(halt), .numInst(numInst)
	);

	rvDatapath i_rvDatapath (
		.CLK(CLK), .rstN(rstN), .pcWrite(pcWrite), .irWrite(irWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
		.wbFromMem(wbFromMem), .pcFromAluOut(pcFromAluOut),
		.iMemData(iMemData), .dMemRdata(dMemRdata),
		.rfRd1(rfRd1), .rfRd2(rfRd2), .imm(imm), .aluResult(aluResult),
		.pc(iMemAddr), .ir(ir), .aluA(aluA), .aluB(aluB),
		.aluOut(aluOut), .regB(dMemWdata), .rfWd(rfWd)
	);

	rvAlu i_rvAlu (
		.a(aluA), .b(aluB), .op(aluOp), .result(aluResult), .zero(zero)
	);

	rvImmGen i_rvImmGen (
		.ir(ir), .imm(imm)
	);

endmodule

`default_nettype wire

//--- design/rvDatapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvDatapath (
	input wire CLK,
	input wire rstN,
	input wire pcWrite,
	input wire irWrite,
	input wire rv_pkg::aluSrcAT aluSrcA,
	input wire rv_pkg::aluSrcBT aluSrcB,
	input wire wbFromMem,
	input wire pcFromAluOut,
	input wire [`RV_XLEN-1:0] iMemData,
	input wire [`RV_XLEN-1:0] dMemRdata,
	input wire [`RV_XLEN-1:0] rfRd1,
	input wire [`RV_XLEN-1:0] rfRd2,
	input wire [`RV_XLEN-1:0] imm,
	input wire [`RV_XLEN-1:0] aluResult,
	output logic [`RV_AW-1:0] pc,
	output rv_pkg::instrT ir,
	output logic [`RV_XLEN-1:0] aluA,
	output logic [`RV_XLEN-1:0] aluB,
	output logic [`RV_XLEN-1:0] aluOut,
	output logic [`RV_XLEN-1:0] regB,
	output logic [`RV_XLEN-1:0] rfWd
);

	logic [`RV_AW-1:0] oldPc;
	logic [`RV_AW-1:0] nextPc;
	logic [`RV_XLEN-1:0] regA;
	logic [`RV_XLEN-1:0] dataReg;
	logic [`RV_XLEN-1:0] pcExt;
	logic [`RV_XLEN-1:0] oldPcExt;
	logic isJal;

	assign pcExt = {{(`RV_XLEN-`RV_AW){1'b0}}, pc};
	assign oldPcExt = {{(`RV_XLEN-`RV_AW){1'b0}}, oldPc};

	// live alu result on fetch, latched target on branch and jump
	assign nextPc = pcFromAluOut ? aluOut[`RV_AW-1:0] : aluResult[`RV_AW-1:0];

	always_ff @(posedge CLK) begin
		if (!rstN)
			pc <= '0;
		else if (pcWrite)
			pc <= nextPc;
	end

	always_ff @(posedge CLK) begin
		if (irWrite) begin
			ir <= iMemData;
			oldPc <= pc;
		end
	end

	// free-running stage registers
	always_ff @(posedge CLK) begin
		regA <= rfRd1;
		regB <= rfRd2;
		dataReg <= dMemRdata;
		aluOut <= aluResult;
	end

	always_comb begin
		case (aluSrcA)
			rv_pkg::srcAPc:    aluA = pcExt;
			rv_pkg::srcAOldPc: aluA = oldPcExt;
			default:           aluA = regA;
		endcase
	end

	always_comb begin
		case (aluSrcB)
			rv_pkg::srcBRegB: aluB = regB;
			rv_pkg::srcBImm:  aluB = imm;
			default:          aluB = 32'd4;
		endcase
	end

	// pc already points past the jal after fetch
	assign isJal = (ir.jType.opcode == `RV_OP_JAL);

	always_comb begin
		if (wbFromMem)
			rfWd = dataReg;
		else if (isJal)
			rfWd = pcExt;
		else
			rfWd = aluOut;
	end

endmodule

`default_nettype wire

//--- design/rvControl.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvControl (
	input wire CLK,
	input wire rstN,
	input wire rv_pkg::instrT ir,
	input wire zero,
	output logic pcWrite,
	output logic irWrite,
	output rv_pkg::aluSrcAT aluSrcA,
	output rv_pkg::aluSrcBT aluSrcB,
	output logic [2:0] aluOp,
	output logic wbFromMem,
	output logic pcFromAluOut,
	output logic rfWe,
	output logic dMemWe,
	output logic halt,
	output logic [`RV_XLEN-1:0] numInst
);

	rv_pkg::stateT state;
	rv_pkg::stateT nextState;
	logic [6:0] opcode;
	logic [2:0] rAluOp;
	logic taken;
	logic retire;

	assign opcode = ir.rType.opcode;

	always_comb begin
		case (ir.rType.funct3)
			`RV_F3_ADDSUB: rAluOp = (ir.rType.funct7 == `RV_F7_SUB) ? `RV_ALU_SUB : `RV_ALU_ADD;
			`RV_F3_SLT:    rAluOp = `RV_ALU_SLT;
			`RV_F3_XOR:    rAluOp = `RV_ALU_XOR;
			`RV_F3_OR:     rAluOp = `RV_ALU_OR;
			`RV_F3_AND:    rAluOp = `RV_ALU_AND;
			default:       rAluOp = `RV_ALU_ADD;
		endcase
	end

	// branch compares with a subtract
	assign taken = ((ir.bType.funct3 == `RV_F3_BEQ) && zero)
		|| ((ir.bType.funct3 == `RV_F3_BNE) && !zero);

	always_comb begin
		nextState = state;
		pcWrite = 1'b0;
		irWrite = 1'b0;
		aluSrcA = rv_pkg::srcARegA;
		aluSrcB = rv_pkg::srcBImm;
		aluOp = `RV_ALU_ADD;
		wbFromMem = 1'b0;
		pcFromAluOut = 1'b0;
		rfWe = 1'b0;
		dMemWe = 1'b0;
		retire = 1'b0;
		case (state)
			rv_pkg::fetch: begin
				irWrite = 1'b1;
				pcWrite = 1'b1;
				aluSrcA = rv_pkg::srcAPc;
				aluSrcB = rv_pkg::srcBFour;
				nextState = rv_pkg::decode;
			end
			rv_pkg::decode: begin
				// branch or jump target into aluOut
				aluSrcA = rv_pkg::srcAOldPc;
				case (opcode)
					`RV_OP_RTYPE, `RV_OP_ITYPE, `RV_OP_LOAD, `RV_OP_STORE:
						nextState = rv_pkg::execute;
					`RV_OP_BRANCH: nextState = rv_pkg::branch;
					`RV_OP_JAL:    nextState = rv_pkg::jump;
					`RV_OP_SYSTEM: begin
						nextState = (ir == `RV_EBREAK) ? rv_pkg::halted : rv_pkg::fetch;
						retire = (ir == `RV_EBREAK);
					end
					default: nextState = rv_pkg::fetch;
				endcase
			end
			rv_pkg::execute: begin
				if (opcode == `RV_OP_RTYPE) begin
					aluSrcB = rv_pkg::srcBRegB;
					aluOp = rAluOp;
				end
				if (opcode == `RV_OP_LOAD)
					nextState = rv_pkg::memRead;
				else if (opcode == `RV_OP_STORE)
					nextState = rv_pkg::memWrite;
				else
					nextState = rv_pkg::writeAlu;
			end
			// address recomputed so aluOut holds steady
			rv_pkg::memRead: nextState = rv_pkg::writeMem;
			rv_pkg::memWrite: begin
				dMemWe = 1'b1;
				retire = 1'b1;
				nextState = rv_pkg::fetch;
			end
			rv_pkg::writeAlu, rv_pkg::writeMem: begin
				rfWe = 1'b1;
				wbFromMem = (state == rv_pkg::writeMem);
				retire = 1'b1;
				nextState = rv_pkg::fetch;
			end
			rv_pkg::branch: begin
				aluSrcB = rv_pkg::srcBRegB;
				aluOp = `RV_ALU_SUB;
				pcFromAluOut = 1'b1;
				pcWrite = taken;
				retire = 1'b1;
				nextState = rv_pkg::fetch;
			end
			rv_pkg::jump: begin
				rfWe = 1'b1;
				pcWrite = 1'b1;
				pcFromAluOut = 1'b1;
				retire = 1'b1;
				nextState = rv_pkg::fetch;
			end
			default: nextState = rv_pkg::halted;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= rv_pkg::fetch;
			numInst <= '0;
		end else begin
			state <= nextState;
			if (retire)
				numInst <= numInst + 1'b1;
		end
	end

	assign halt = (state == rv_pkg::halted);

endmodule

`default_nettype wire

//--- design/rvImmGen.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvImmGen (
	input wire rv_pkg::instrT ir,
	output logic [`RV_XLEN-1:0] imm
);

	always_comb begin
		case (ir.iType.opcode)
			`RV_OP_ITYPE, `RV_OP_LOAD:
				imm = {{20{ir.iType.imm11to0[11]}}, ir.iType.imm11to0};
			`RV_OP_STORE:
				imm = {{20{ir.sType.imm11to5[6]}}, ir.sType.imm11to5, ir.sType.imm4to0};
			// offsets are in halfwords, bit 0 always zero
			`RV_OP_BRANCH:
				imm = {{20{ir.bType.imm12}}, ir.bType.imm11, ir.bType.imm10to5,
					ir.bType.imm4to1, 1'b0};
			`RV_OP_JAL:
				imm = {{12{ir.jType.imm20}}, ir.jType.imm19to12, ir.jType.imm11,
					ir.jType.imm10to1, 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/rvAlu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_consts.svh"

module rvAlu (
	input wire [`RV_XLEN-1:0] a,
	input wire [`RV_XLEN-1:0] b,
	input wire [2:0] op,
	output logic [`RV_XLEN-1:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			`RV_ALU_ADD: result = a + b;
			`RV_ALU_SUB: result = a - b;
			`RV_ALU_AND: result = a & b;
			`RV_ALU_OR:  result = a | b;
			`RV_ALU_XOR: result = a ^ b;
			// signed compare
			`RV_ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:     result = a + b;
		endcase
	end

	// shared by beq and bne
	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	typedef struct packed {
		logic [11:0] imm11to0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iTypeT;

	typedef struct packed {
		logic [6:0] imm11to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4to0;
		logic [6:0] opcode;
	} sTypeT;

	// branch offset is scattered across both ends of the word
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bTypeT;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		sTypeT sType;
		bTypeT bType;
		jTypeT jType;
	} instrT;

	typedef enum logic [3:0] {
		fetch, decode, execute, memRead, memWrite,
		writeAlu, writeMem, branch, jump, halted
	} stateT;

	typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARegA} aluSrcAT;
	typedef enum logic [1:0] {srcBRegB, srcBImm, srcBFour} aluSrcBT;

endpackage

`default_nettype wire

//--- design/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN 32
`define RV_AW 12

`define RV_OP_RTYPE  7'b0110011
`define RV_OP_ITYPE  7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111
`define RV_OP_SYSTEM 7'b1110011

`define RV_F3_ADDSUB 3'b000
`define RV_F3_SLT    3'b010
`define RV_F3_XOR    3'b100
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F7_SUB    7'b0100000

`define RV_ALU_ADD 3'd0
`define RV_ALU_SUB 3'd1
`define RV_ALU_AND 3'd2
`define RV_ALU_OR  3'd3
`define RV_ALU_XOR 3'd4
`define RV_ALU_SLT 3'd5

`define RV_EBREAK 32'h00100073

`endif
